// ==== cart_loader.sv ====
`timescale 1ns/1ps
// Cartridge loading top level
// Download port in, cheat code, region request and mapped ROM address out
module cart_loader import load_pkg::*, map_pkg::*; (
	input  logic                     clk_sys,
	input  logic                     reset,

	// Download port
	input  logic                     ioctl_download,
	input  logic [ioctl_index_w-1:0] ioctl_index,
	input  logic                     ioctl_wr,
	input  logic [ioctl_addr_w-1:0]  ioctl_addr,
	input  logic [ioctl_data_w-1:0]  ioctl_data,

	// Console bus
	input  logic                     page_ce_n,
	input  logic                     bus_rnw,
	input  logic [bus_va_w:1]        bus_va,
	input  logic [bus_data_w-1:0]    bus_vdo,

	output logic [code_w-1:0]        code,
	output logic                     code_valid,
	output logic                     code_reset,
	output region_t                  region_req,
	output logic                     region_set,
	output logic [bus_va_w:1]        rom_va,
	output logic                     rom_cart_mode
);

	load_bus_if lb ();

	load_ctrl i_ctrl (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.lb             (lb.ctrl)
	);

	//////////////////////////////////////////////////
	// Datapaths

	cheat_code_loader i_cheat (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.lb         (lb.sink),
		.code       (code),
		.code_valid (code_valid),
		.code_reset (code_reset)
	);

	header_scan i_header (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.lb         (lb.sink),
		.region_req (region_req),
		.region_set (region_set)
	);

	rom_mapper i_mapper (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.lb            (lb.sink),
		.page_ce_n     (page_ce_n),
		.bus_rnw       (bus_rnw),
		.bus_va        (bus_va),
		.bus_vdo       (bus_vdo),
		.rom_va        (rom_va),
		.rom_cart_mode (rom_cart_mode)
	);

endmodule

// ==== cart_loader_chk.sv ====
`timescale 1ns/1ps
// Concurrent checks on the cart_loader outputs
// Bound into every cart_loader instance
module cart_loader_chk (
	input logic clk_sys,
	input logic reset,
	input logic ioctl_download,
	input logic code_valid,
	input logic code_reset,
	input logic region_set
);

	int valid_fails = 0;
	int overlap_fails = 0;
	int region_fails = 0;

	// Strobe lasts one cycle
	assert property (@(posedge clk_sys) disable iff (reset)
		code_valid |=> !code_valid)
	else begin
		valid_fails++;
		$error("code_valid high two cycles running");
	end

	assert property (@(posedge clk_sys) disable iff (reset)
		!(code_reset && code_valid))
	else begin
		overlap_fails++;
		$error("code_reset and code_valid high together");
	end

	// Region request drops once the download has ended
	assert property (@(posedge clk_sys) disable iff (reset)
		(!ioctl_download && $past(!ioctl_download) && $past(!ioctl_download, 2)) |-> !region_set)
	else begin
		region_fails++;
		$error("region_set high with no download for three cycles");
	end

endmodule

bind cart_loader cart_loader_chk i_chk (
	.clk_sys        (clk_sys),
	.reset          (reset),
	.ioctl_download (ioctl_download),
	.code_valid     (code_valid),
	.code_reset     (code_reset),
	.region_set     (region_set)
);

// ==== cheat_code_loader.sv ====
`timescale 1ns/1ps
// Cheat code assembly from 16-bit download words
// Each 16-byte group of the cheat file gives one code, strobed out on its last word
module cheat_code_loader import load_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	load_bus_if.sink          lb,
	output logic [code_w-1:0] code,
	output logic              code_valid,
	output logic              code_reset
);

	// Code layout
	// {flags 127:96, address 95:64, compare 63:32, replace 31:0}
	// Each field arrives low word first

	logic [code_slot_w-1:0] word_sel;   // Word within the group
	logic [code_slot_w-1:0] slot;       // Word position inside the code
	logic                   word_wr;

	assign word_sel = lb.addr[code_slot_w:1];
	assign word_wr  = lb.code_wr && !lb.addr[0];

	// Fields fill from the top, low word before high word
	assign slot = {~word_sel[code_slot_w-1:1], word_sel[0]};

	always_ff @(posedge clk_sys) begin
		if (word_wr) begin
			code[slot*code_word_w +: code_word_w] <= lb.data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_valid <= 1'b0;
			code_reset <= 1'b0;
		end else begin
			code_valid <= word_wr && (word_sel == '1);   // Replace top word, byte 14
			// First word of the file starts a new code list
			code_reset <= lb.code_wr && (lb.addr == '0);
		end
	end

endmodule

// ==== header_scan.sv ====
`timescale 1ns/1ps
// Cartridge header scan
// Picks up the region byte of a ROM as it downloads and requests that region
// region_set stays high from the region byte to the end of the download
module header_scan import load_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset,
	load_bus_if.sink lb,
	output region_t  region_req,
	output logic     region_set
);

	logic    hdr_hit;
	region_t hdr_region;

	assign hdr_hit = lb.rom_wr && (lb.addr == hdr_region_addr);

	// First region character only
	always_comb begin
		case (lb.data[7:0])
			hdr_char_jp: hdr_region = region_jp;
			hdr_char_us: hdr_region = region_us;
			default:     hdr_region = region_eu;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			region_req <= region_jp;
			region_set <= 1'b0;
		end else begin
			if (lb.rom_start || lb.rom_end) begin
				region_set <= 1'b0;   // New image or done
			end
			if (hdr_hit) begin
				region_req <= hdr_region;
				region_set <= 1'b1;
			end
		end
	end

endmodule

// ==== load_bus_if.sv ====
`timescale 1ns/1ps
// Qualified download writes from the control block to the datapaths
// The control block drives everything, the datapaths only listen
interface load_bus_if import load_pkg::*; ();

	logic                    rom_wr;      // ROM write strobe
	logic                    code_wr;     // Cheat write strobe
	logic [ioctl_addr_w-1:0] addr;
	logic [ioctl_data_w-1:0] data;
	logic                    cart_mode;   // Index bit 6
	logic                    rom_active;
	logic                    rom_start;
	logic                    rom_end;

	modport ctrl (
		output rom_wr,
		output code_wr,
		output addr,
		output data,
		output cart_mode,
		output rom_active,
		output rom_start,
		output rom_end
	);

	modport sink (
		input rom_wr,
		input code_wr,
		input addr,
		input data,
		input cart_mode,
		input rom_active,
		input rom_start,
		input rom_end
	);

endinterface

// ==== load_ctrl.sv ====
`timescale 1ns/1ps
// Download port front end
// Classifies each download by its index and registers the port onto the load bus
module load_ctrl import load_pkg::*; (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     ioctl_download,
	input  logic [ioctl_index_w-1:0] ioctl_index,
	input  logic                     ioctl_wr,
	input  logic [ioctl_addr_w-1:0]  ioctl_addr,
	input  logic [ioctl_data_w-1:0]  ioctl_data,
	load_bus_if.ctrl                 lb
);

	load_kind_t kind_d;
	load_kind_t kind_q;   // Kind seen at the previous edge

	//////////////////////////////////////////////////
	// Download kind

	always_comb begin
		kind_d = load_none;
		if (ioctl_download) begin
			if (&ioctl_index) begin
				kind_d = load_code;
			end else if (ioctl_index[5:0] <= rom_index_max) begin
				kind_d = load_rom;
			end else begin
				kind_d = load_other;   // CD data, saves and the like
			end
		end
	end

	//////////////////////////////////////////////////
	// Load bus strobes and levels

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			kind_q        <= load_none;
			lb.rom_wr     <= 1'b0;
			lb.code_wr    <= 1'b0;
			lb.cart_mode  <= 1'b0;
			lb.rom_active <= 1'b0;
			lb.rom_start  <= 1'b0;
			lb.rom_end    <= 1'b0;
		end else begin
			kind_q        <= kind_d;
			lb.rom_wr     <= ioctl_wr && (kind_d == load_rom);
			lb.code_wr    <= ioctl_wr && (kind_d == load_code);
			lb.cart_mode  <= ioctl_index[cart_mode_bit];
			lb.rom_active <= (kind_d == load_rom);
			// Edges of the ROM download
			lb.rom_start  <= (kind_d == load_rom) && (kind_q != load_rom);
			lb.rom_end    <= (kind_q == load_rom) && (kind_d != load_rom);
		end
	end

	// Write address and data, qualified by the strobes above
	always_ff @(posedge clk_sys) begin
		lb.addr <= ioctl_addr;
		lb.data <= ioctl_data;
	end

endmodule

// ==== load_pkg.sv ====
// Download port definitions shared by the loader front end and its datapaths
// Widths, download kinds, cartridge header and cheat-code constants
package load_pkg;

	localparam int ioctl_addr_w  = 25;   // Byte address
	localparam int ioctl_data_w  = 16;
	localparam int ioctl_index_w = 8;

	// Kind of the current download
	typedef enum logic [1:0] {
		load_none,
		load_rom,     // Index low six bits 0 or 1
		load_code,    // Index all ones
		load_other
	} load_kind_t;

	localparam logic [5:0] rom_index_max = 6'd1;
	localparam int         cart_mode_bit = 6;   // Cartridge-format ROM

	// Cartridge header
	localparam logic [ioctl_addr_w-1:0] hdr_region_addr = 25'h1F0;
	localparam logic [7:0]              hdr_char_jp     = "J";
	localparam logic [7:0]              hdr_char_us     = "U";

	typedef enum logic [1:0] {
		region_jp = 2'd0,
		region_us = 2'd1,
		region_eu = 2'd2
	} region_t;

	// Cheat code, one code per 16-byte group
	localparam int code_w      = 128;
	localparam int code_words  = 8;
	localparam int code_word_w = code_w / code_words;
	localparam int code_slot_w = $clog2(code_words);

endpackage

// ==== map_pkg.sv ====
// Cartridge address map definitions
// Bus word address, bank registers and ROM size mask field
package map_pkg;

	localparam int bus_va_w   = 23;   // Word address, bits 23:1
	localparam int bus_data_w = 16;

	// Bank registers
	localparam int bank_count   = 8;
	localparam int bank_w       = 5;
	localparam int bank_sel_w   = $clog2(bank_count);
	localparam int bank_sel_lsb = 19;   // Window select, bits 21:19

	// Paging register select on the bus, bits 3:1
	localparam int page_sel_lsb = 1;

	// Size mask field, byte address bits 23:13
	localparam int mask_msb = 23;
	localparam int mask_lsb = 13;

	// Low word-address bits always passed through
	localparam int page_keep_bits = 12;

	// Top mask bits, any set means more than 4 MB
	localparam int big_rom_bits = 2;

endpackage

// ==== rom_mapper.sv ====
`timescale 1ns/1ps
// ROM size mask and bank mapper
// Builds the size mask while a cart ROM downloads and maps bus word addresses
// through eight bank registers, which the bus may rewrite on ROMs over 4 MB
module rom_mapper import map_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	load_bus_if.sink              lb,
	input  logic                  page_ce_n,
	input  logic                  bus_rnw,
	input  logic [bus_va_w:1]     bus_va,
	input  logic [bus_data_w-1:0] bus_vdo,
	output logic [bus_va_w:1]     rom_va,
	output logic                  rom_cart_mode
);

	logic [mask_msb:mask_lsb] rom_mask;
	logic [bank_w-1:0]        bank_q [bank_count];
	logic                     big_rom;
	logic                     page_ce_q;
	logic                     page_wr;    // Paging write seen, apply next edge
	logic [bank_sel_w-1:0]    page_sel;
	logic [bank_w-1:0]        page_dat;
	logic [bank_sel_w-1:0]    win_sel;

	//////////////////////////////////////////////////
	// Size mask

	assign big_rom = |rom_mask[mask_msb -: big_rom_bits];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_mask      <= '0;
			rom_cart_mode <= 1'b0;
		end else if (lb.rom_wr) begin
			rom_cart_mode <= lb.cart_mode;
			if (lb.cart_mode) begin
				if (lb.addr == '0) begin
					rom_mask <= '0;   // Start of a new image
				end else begin
					rom_mask <= rom_mask | lb.addr[mask_msb:mask_lsb];
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Paging writes

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_ce_q <= 1'b1;
			page_wr   <= 1'b0;
		end else begin
			page_ce_q <= page_ce_n;
			// Falling edge of the strobe, write cycle, register 0 excluded
			page_wr   <= page_ce_q && !page_ce_n && !bus_rnw &&
				(|bus_va[page_sel_lsb +: bank_sel_w]);
		end
	end

	always_ff @(posedge clk_sys) begin
		page_sel <= bus_va[page_sel_lsb +: bank_sel_w];
		page_dat <= bus_vdo[bank_w-1:0];
	end

	always_ff @(posedge clk_sys) begin
		if (reset || lb.rom_active) begin
			for (int i = 0; i < bank_count; i++) begin
				bank_q[i] <= bank_w'(i);   // Identity map
			end
		end else if (page_wr && big_rom) begin
			bank_q[page_sel] <= page_dat;
		end
	end

	//////////////////////////////////////////////////
	// Address translation

	assign win_sel = bus_va[bank_sel_lsb +: bank_sel_w];
	assign rom_va  = {bank_q[win_sel], bus_va[bank_sel_lsb-1:1]} &
		{rom_mask, {page_keep_bits{1'b1}}};

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the cart_loader testbench with Verilator and runs it
# Exit status is zero only when the run reports a pass
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_cart_loader -f verilog.f || exit 1
out=$(./obj_dir/Vtb_cart_loader)
echo "$out"
echo "$out" | grep -qx "TEST PASS" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== tb_cart_loader.sv ====
`timescale 1ns/1ps
// Directed testbench for the cartridge loading top level
// Runs cheat code, header region, size mask and bank mapper tests, then prints counts
module tb_cart_loader import load_pkg::*, map_pkg::*; ();

	localparam int watchdog_cycles = 20000;   // Tests need a few hundred cycles
	localparam logic [bus_va_w:1] win3_va = {2'b00, 3'd3, 18'h2A5A5};
	localparam int rom_2mb = 2 * 1024 * 1024;   // ROM image sizes in bytes
	localparam int rom_8mb = 8 * 1024 * 1024;

	logic                     clk_sys;
	logic                     reset;
	logic                     ioctl_download;
	logic [ioctl_index_w-1:0] ioctl_index;
	logic                     ioctl_wr;
	logic [ioctl_addr_w-1:0]  ioctl_addr;
	logic [ioctl_data_w-1:0]  ioctl_data;
	logic                     page_ce_n;
	logic                     bus_rnw;
	logic [bus_va_w:1]        bus_va;
	logic [bus_data_w-1:0]    bus_vdo;
	logic [code_w-1:0]        code;
	logic                     code_valid;
	logic                     code_reset;
	region_t                  region_req;
	logic                     region_set;
	logic [bus_va_w:1]        rom_va;
	logic                     rom_cart_mode;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int valid_count = 0;   // code_valid pulses seen
	int reset_count = 0;
	int assert_fails;

	cart_loader i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("Watchdog expired, the tests did not finish in %0d cycles", watchdog_cycles);
		$display("TEST FAIL");
		$finish;
	end

	// Outputs are stable at the falling edge
	always @(negedge clk_sys) begin
		if (code_valid === 1'b1) valid_count++;
		if (code_reset === 1'b1) reset_count++;
	end

	//////////////////////////////////////////////////
	// Helpers

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		errors++;
		$display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, got);
	endtask

	task automatic close_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("%s passed", name);
		end else begin
			tests_failed++;
			$display("%s failed with %0d errors", name, errors - start_errors);
		end
	endtask

	task automatic start_download(input logic [ioctl_index_w-1:0] index);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		wait_cycles(1);
	endtask

	task automatic end_download();
		ioctl_download = 1'b0;
		wait_cycles(3);
	endtask

	task automatic write_word(input logic [ioctl_addr_w-1:0] addr,
		input logic [ioctl_data_w-1:0] data);
		ioctl_addr = addr;
		ioctl_data = data;
		ioctl_wr   = 1'b1;
		wait_cycles(1);
		ioctl_wr   = 1'b0;
	endtask

	// Field layout of a cheat code by byte offset in its group
	function automatic logic [code_w-1:0] place_word(input logic [code_w-1:0] acc,
		input logic [3:0] offset, input logic [15:0] w);
		logic [code_w-1:0] r;
		r = acc;
		case (offset)
			4'd0:    r[111:96] = w;
			4'd2:    r[127:112] = w;
			4'd4:    r[79:64] = w;
			4'd6:    r[95:80] = w;
			4'd8:    r[47:32] = w;
			4'd10:   r[63:48] = w;
			4'd12:   r[15:0] = w;
			4'd14:   r[31:16] = w;
			default: r = acc;
		endcase
		return r;
	endfunction

	// Window bits replaced by the bank and the word address wrapped to the ROM size
	function automatic logic [bus_va_w:1] map_expect(input logic [bank_w-1:0] bank,
		input logic [bus_va_w:1] va, input int rom_bytes);
		logic [bus_va_w:1] flat;
		flat = {bank, va[18:1]};
		return bus_va_w'(flat % (rom_bytes / 2));
	endfunction

	// Cart-mode ROM image ending at last_addr
	task automatic rom_image(input logic [ioctl_addr_w-1:0] last_addr);
		start_download(8'h40);
		write_word('0, 16'h4E4F);
		write_word(25'h2, 16'h5241);
		write_word(last_addr, 16'hFFFF);
		end_download();
	endtask

	task automatic page_write(input logic [2:0] sel, input logic [4:0] value);
		bus_va    = {20'd0, sel};
		bus_vdo   = {11'd0, value};
		bus_rnw   = 1'b0;
		page_ce_n = 1'b0;
		wait_cycles(2);
		page_ce_n = 1'b1;
		bus_rnw   = 1'b1;
		wait_cycles(3);
	endtask

	task automatic region_image(input logic [7:0] region_char, input region_t exp_region);
		start_download(8'h01);
		write_word('0, 16'h1234);
		write_word(hdr_region_addr, {8'h20, region_char});
		wait_cycles(3);
		if (region_req !== exp_region)
			report_mismatch("region_req", 128'(region_req), 128'(exp_region));
		if (region_set !== 1'b1)
			report_mismatch("region_set", 128'(region_set), 128'(1));
		end_download();
		if (region_set !== 1'b0)
			report_mismatch("region_set", 128'(region_set), 128'(0));
	endtask

	//////////////////////////////////////////////////
	// Directed tests

	task automatic test_cheat_code();
		logic [code_w-1:0]       exp_code;
		logic [ioctl_data_w-1:0] word;
		logic [ioctl_addr_w-1:0] addr;
		int start;
		int valid_base;
		int reset_base;
		start      = errors;
		valid_base = valid_count;
		reset_base = reset_count;
		exp_code   = '0;
		start_download(8'hFF);
		for (int i = 0; i < code_words; i++) begin
			word     = {4'hC, 4'(i), 4'h5, 4'(15 - i)};
			addr     = 25'(2 * i);
			exp_code = place_word(exp_code, addr[3:0], word);
			write_word(addr, word);
			if (i == 0) begin
				wait_cycles(3);
				if (reset_count - reset_base != 1)
					report_mismatch("code_reset pulses", 128'(reset_count - reset_base), 128'(1));
			end
		end
		wait_cycles(3);
		if (code !== exp_code) report_mismatch("code", code, exp_code);
		if (valid_count - valid_base != 1)
			report_mismatch("code_valid pulses", 128'(valid_count - valid_base), 128'(1));
		end_download();
		close_test("cheat_code", start);
	endtask

	task automatic test_header_region();
		int start;
		start = errors;
		region_image("U", region_us);
		region_image("J", region_jp);
		region_image("X", region_eu);
		close_test("header_region", start);
	endtask

	task automatic test_size_mask();
		logic [bus_va_w:1] exp_va;
		int start;
		start = errors;
		rom_image(25'(rom_2mb - 2));
		if (rom_cart_mode !== 1'b1)
			report_mismatch("rom_cart_mode", 128'(rom_cart_mode), 128'(1));
		bus_va = '1;
		wait_cycles(1);
		if (rom_va[bus_va_w:21] !== '0)
			report_mismatch("rom_va[23:21]", 128'(rom_va[bus_va_w:21]), 128'(0));
		exp_va = map_expect(5'd7, bus_va, rom_2mb);
		if (rom_va !== exp_va)
			report_mismatch("rom_va", 128'(rom_va), 128'(exp_va));
		close_test("size_mask", start);
	endtask

	task automatic test_bank_switch();
		logic [bus_va_w:1] exp_va;
		int start;
		start = errors;
		rom_image(25'(rom_8mb - 2));
		page_write(3'd3, 5'd9);
		bus_va = win3_va;
		wait_cycles(1);
		exp_va = map_expect(5'd9, win3_va, rom_8mb);
		if (rom_va !== exp_va)
			report_mismatch("rom_va", 128'(rom_va), 128'(exp_va));
		close_test("bank_switch", start);
	endtask

	task automatic test_bank_identity();
		logic [bus_va_w:1] exp_va;
		int start;
		start  = errors;
		exp_va = map_expect(5'd3, win3_va, rom_2mb);
		// New download puts bank 3 back to identity
		rom_image(25'(rom_2mb - 2));
		bus_va = win3_va;
		wait_cycles(1);
		if (rom_va !== exp_va)
			report_mismatch("rom_va", 128'(rom_va), 128'(exp_va));
		page_write(3'd3, 5'd9);   // Ignored on a small ROM
		bus_va = win3_va;
		wait_cycles(1);
		if (rom_va !== exp_va)
			report_mismatch("rom_va", 128'(rom_va), 128'(exp_va));
		close_test("bank_identity", start);
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		page_ce_n      = 1'b1;
		bus_rnw        = 1'b1;
		bus_va         = '0;
		bus_vdo        = '0;
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;
		wait_cycles(2);
		test_cheat_code();
		test_header_region();
		test_size_mask();
		test_bank_switch();
		test_bank_identity();
		assert_fails = i_dut.i_chk.valid_fails + i_dut.i_chk.overlap_fails +
			i_dut.i_chk.region_fails;
		$display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
load_pkg.sv
map_pkg.sv
load_bus_if.sv
load_ctrl.sv
cheat_code_loader.sv
header_scan.sv
rom_mapper.sv
cart_loader.sv
cart_loader_chk.sv
tb_cart_loader.sv
